/* hw/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    localparam int ISR_W    = 16;
    localparam int OP_W     = 6;
    localparam int MODE_W   = 2;
    localparam int REG_W    = 3;
    localparam int NUM_REGS = 8;

    typedef struct packed {
        logic [OP_W-1:0]   ex_op;
        logic [MODE_W-1:0] f_mode;
        logic [REG_W-1:0]  f_reg;
        logic [MODE_W-1:0] t_mode;
        logic [REG_W-1:0]  t_reg;
    } isr_fields_t;

    // opcode split into group and two-bit variant
    typedef struct packed {
        logic [OP_W-3:0]       op_group;
        logic [1:0]            op_sub;
        logic [ISR_W-OP_W-1:0] operands;
    } isr_group_t;

    typedef union packed {
        isr_fields_t fields;
        isr_group_t  grp;
    } isr_u;

    localparam logic [MODE_W-1:0] MODE_D  = 2'b00;
    localparam logic [MODE_W-1:0] MODE_I  = 2'b01;
    localparam logic [MODE_W-1:0] MODE_MI = 2'b10;
    localparam logic [MODE_W-1:0] MODE_IP = 2'b11;

    localparam logic [OP_W-1:0] OP_HLT = 6'b000000;
    localparam logic [OP_W-1:0] OP_CLR = 6'b000100;
    localparam logic [OP_W-1:0] OP_ASL = 6'b001000;
    localparam logic [OP_W-1:0] OP_ASR = 6'b001001;
    localparam logic [OP_W-1:0] OP_RLC = 6'b001010;
    localparam logic [OP_W-1:0] OP_RRC = 6'b001011;
    localparam logic [OP_W-1:0] OP_LSL = 6'b001100;
    localparam logic [OP_W-1:0] OP_LSR = 6'b001101;
    localparam logic [OP_W-1:0] OP_ROL = 6'b001110;
    localparam logic [OP_W-1:0] OP_ROR = 6'b001111;
    localparam logic [OP_W-1:0] OP_MOV = 6'b010000;
    localparam logic [OP_W-1:0] OP_JMP = 6'b010001;
    localparam logic [OP_W-1:0] OP_RET = 6'b010010;
    localparam logic [OP_W-1:0] OP_RIT = 6'b010011;
    localparam logic [OP_W-1:0] OP_ADD = 6'b010100;
    localparam logic [OP_W-1:0] OP_RJP = 6'b010101;
    localparam logic [OP_W-1:0] OP_ADC = 6'b010110;
    localparam logic [OP_W-1:0] OP_SUB = 6'b011000;
    localparam logic [OP_W-1:0] OP_SBC = 6'b011010;
    localparam logic [OP_W-1:0] OP_CMP = 6'b011011;
    localparam logic [OP_W-1:0] OP_OR  = 6'b100000;
    localparam logic [OP_W-1:0] OP_XOR = 6'b100001;
    localparam logic [OP_W-1:0] OP_AND = 6'b100010;
    localparam logic [OP_W-1:0] OP_BIT = 6'b100011;
    localparam logic [OP_W-1:0] OP_MUL = 6'b100100;
    localparam logic [OP_W-1:0] OP_JSR = 6'b101100;
    localparam logic [OP_W-1:0] OP_RJS = 6'b101101;
    localparam logic [OP_W-1:0] OP_SVC = 6'b101110;

    localparam logic [OP_W-3:0] GRP_SHIFT_A = 4'b0010;
    localparam logic [OP_W-3:0] GRP_SHIFT_L = 4'b0011;
    localparam logic [OP_W-3:0] GRP_NOP     = 4'b0111;
    localparam logic [OP_W-3:0] GRP_BR      = 4'b1100;
    localparam logic [OP_W-3:0] GRP_RB      = 4'b1110;

    localparam logic [REG_W-1:0] REG_SP = 3'd6;
    localparam logic [REG_W-1:0] REG_PC = 3'd7;

endpackage

/* hw/opcode_decoder.sv */
`timescale 1ns/1ps

module opcode_decoder (
    input  cpu_ctrl_pkg::isr_u isr,
    input  logic               psw_n,
    input  logic               psw_z,
    input  logic               psw_v,
    input  logic               psw_c,
    output logic               op_dst_write,
    output logic               op_jump,
    output logic               op_stack_ret,
    output logic               op_call,
    output logic               op_rjs,
    output logic               op_branch_taken,
    output logic               op_rel_branch,
    output logic               op_mem_idle,
    output logic               f_is_ip,
    output logic               f_is_mi,
    output logic               t_is_ip,
    output logic               t_is_d
);
    import cpu_ctrl_pkg::*;

    logic [OP_W-1:0] op;
    logic [OP_W-3:0] op_grp;
    logic            is_shift;
    logic            is_branch;
    logic            flag_sel;

    assign op       = isr.fields.ex_op;
    assign op_grp   = isr.grp.op_group;
    assign is_shift = (op_grp == GRP_SHIFT_A) || (op_grp == GRP_SHIFT_L);

    assign f_is_ip = (isr.fields.f_mode == MODE_IP);
    assign f_is_mi = (isr.fields.f_mode == MODE_MI);
    assign t_is_ip = (isr.fields.t_mode == MODE_IP);
    assign t_is_d  = (isr.fields.t_mode == MODE_D);

    // results that land in a direct-mode destination register
    assign op_dst_write = is_shift ||
                          (op inside {OP_CLR, OP_MOV, OP_ADD, OP_ADC, OP_RJP,
                                      OP_OR, OP_XOR, OP_AND});

    assign op_jump      = (op inside {OP_JMP, OP_RET, OP_RIT});
    assign op_stack_ret = (op == OP_RET) || (op == OP_RIT);
    assign op_call      = (op inside {OP_JSR, OP_RJS, OP_SVC});
    assign op_rjs       = (op == OP_RJS);

    // low opcode bits pick N, Z, V or C
    always_comb begin
        case (isr.grp.op_sub)
            2'd0:    flag_sel = psw_n;
            2'd1:    flag_sel = psw_z;
            2'd2:    flag_sel = psw_v;
            default: flag_sel = psw_c;
        endcase
    end

    assign op_rel_branch   = (op_grp == GRP_RB);
    assign is_branch       = (op_grp == GRP_BR) || op_rel_branch;
    assign op_branch_taken = is_branch && flag_sel;

    assign op_mem_idle = is_branch || (op_grp == GRP_NOP) ||
                         (op inside {OP_HLT, OP_CLR, OP_ASL, OP_ASR, OP_RLC, OP_RRC,
                                     OP_LSL, OP_LSR, OP_ROL, OP_ROR, OP_MOV, OP_JMP,
                                     OP_RET, OP_RIT, OP_ADD, OP_RJP, OP_ADC, OP_SUB,
                                     OP_SBC, OP_CMP, OP_OR, OP_XOR, OP_AND, OP_BIT,
                                     OP_MUL, OP_JSR, OP_RJS, OP_SVC});

endmodule

/* hw/reg_select.sv */
`timescale 1ns/1ps

module reg_select (
    input  logic                              clk,
    input  logic                              rst,
    input  cpu_ctrl_pkg::isr_u                isr,
    input  logic                              if_0,
    input  logic                              if_1,
    input  logic                              ff_0,
    input  logic                              ff_1,
    input  logic                              tf_0,
    input  logic                              tf_1,
    input  logic                              ex_1,
    input  logic                              op_dst_write,
    input  logic                              op_jump,
    input  logic                              op_stack_ret,
    input  logic                              op_call,
    input  logic                              op_rjs,
    input  logic                              op_branch_taken,
    input  logic                              f_is_ip,
    input  logic                              t_is_ip,
    input  logic                              t_is_d,
    output logic [cpu_ctrl_pkg::NUM_REGS-1:0] reg_read,
    output logic [cpu_ctrl_pkg::NUM_REGS-1:0] reg_write
);
    import cpu_ctrl_pkg::*;

    logic [NUM_REGS-1:0] read_d;
    logic [NUM_REGS-1:0] write_d;
    logic                f_access;

    function automatic logic [NUM_REGS-1:0] sel(input logic [REG_W-1:0] r, input logic en);
        sel = en ? (NUM_REGS'(1) << r) : '0;
    endfunction

    // source register touched in ff_0, again in ff_1 for post-increment
    assign f_access = ff_0 || (ff_1 && f_is_ip);

    assign read_d = sel(isr.fields.f_reg, f_access) |
                    sel(isr.fields.t_reg, tf_0 || (tf_1 && t_is_ip)) |
                    sel(REG_SP, op_stack_ret) |
                    sel(REG_PC, if_0 || if_1 || (op_rjs && ex_1));

    assign write_d = sel(isr.fields.f_reg, f_access) |
                     sel(isr.fields.t_reg, tf_1 && t_is_ip) |
                     sel(isr.fields.t_reg, op_dst_write && t_is_d) |
                     sel(REG_PC, if_1 || op_jump || op_branch_taken || (op_call && ex_1));

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_read  <= '0;
            reg_write <= '0;
        end else begin
            reg_read  <= read_d;
            reg_write <= write_d;
        end
    end

endmodule

/* hw/alu_control.sv */
`timescale 1ns/1ps

module alu_control (
    input  logic               clk,
    input  logic               rst,
    input  cpu_ctrl_pkg::isr_u isr,
    input  logic               if_0,
    input  logic               if_1,
    input  logic               ff_0,
    input  logic               ff_1,
    input  logic               ff_2,
    input  logic               tf_0,
    input  logic               tf_1,
    input  logic               ex_1,
    input  logic               psw_c,
    input  logic               f_is_mi,
    input  logic               op_rel_branch,
    output logic               mda,
    output logic               b0b,
    output logic               als,
    output logic               alu_x,
    output logic               alu_y,
    output logic               alu_z,
    output logic               alu_u,
    output logic               alu_v,
    output logic               shs,
    output logic               sft_a,
    output logic               sft_b,
    output logic               sft_c,
    output logic               sft_d,
    output logic               sft_e,
    output logic               sft_r,
    output logic               sft_l,
    output logic               set_psw
);
    import cpu_ctrl_pkg::*;

    logic [OP_W-1:0] op;
    logic [1:0]      sub;
    logic            sh_a;
    logic            sh_l;
    logic            is_shift;
    logic            op_asr;
    logic            op_rlc;
    logic            op_rrc;
    logic            op_lsr;
    logic            op_rol;
    logic            op_ror;
    logic            op_br;
    logic            xfer;
    logic            arith;
    logic            logic_op;
    logic            calls;
    logic            seq;

    assign op  = isr.fields.ex_op;
    assign sub = isr.grp.op_sub;

    // shift variant from the group view
    assign sh_a     = (isr.grp.op_group == GRP_SHIFT_A);
    assign sh_l     = (isr.grp.op_group == GRP_SHIFT_L);
    assign is_shift = sh_a || sh_l;
    assign op_asr   = sh_a && (sub == 2'd1);
    assign op_rlc   = sh_a && (sub == 2'd2);
    assign op_rrc   = sh_a && (sub == 2'd3);
    assign op_lsr   = sh_l && (sub == 2'd1);
    assign op_rol   = sh_l && (sub == 2'd2);
    assign op_ror   = sh_l && (sub == 2'd3);
    assign op_br    = (isr.grp.op_group == GRP_BR);

    assign xfer     = (op inside {OP_MOV, OP_JMP, OP_RET, OP_RIT});
    assign arith    = (op inside {OP_ADD, OP_ADC, OP_RJP, OP_SUB, OP_SBC, OP_CMP});
    assign logic_op = (op inside {OP_OR, OP_XOR, OP_AND, OP_BIT});
    assign calls    = (op inside {OP_JSR, OP_RJS, OP_SVC});

    // microcycles other than ff_1 that route operands through the ALU
    assign seq = if_0 || if_1 || ff_0 || ff_2 || tf_0 || tf_1;

    always_ff @(posedge clk) begin
        if (rst) begin
            {mda, b0b, als, alu_x, alu_y, alu_z, alu_u, alu_v} <= '0;
            {shs, sft_a, sft_b, sft_c, sft_d, sft_e, sft_r, sft_l, set_psw} <= '0;
        end else begin
            mda   <= ff_2 || is_shift || arith || logic_op || op_rel_branch;
            b0b   <= (op == OP_MOV) || (op == OP_JMP) || arith || logic_op || calls ||
                     op_br || op_rel_branch || ex_1;
            als   <= seq || ff_1 || (op == OP_CLR) || xfer || arith || logic_op ||
                     calls || op_br || op_rel_branch || ex_1;
            alu_x <= (f_is_mi && ff_0) || (op inside {OP_SUB, OP_SBC, OP_CMP});
            alu_y <= seq || xfer || arith || calls || op_br || ex_1;
            alu_z <= (op == OP_OR) || op_rel_branch;
            // carry in
            alu_u <= if_1 || tf_1 || (op == OP_SUB) || (op == OP_CMP) ||
                     (psw_c && ((op == OP_ADC) || (op == OP_SBC)));
            alu_v <= seq || xfer || arith || (op == OP_XOR) || calls || op_br ||
                     op_rel_branch || ex_1;

            shs   <= is_shift;
            sft_a <= op_asr;
            sft_b <= op_rol;
            sft_c <= op_lsr || op_rol || op_rlc;
            sft_d <= op_ror;
            sft_e <= op_rlc || op_rrc;
            sft_r <= op_asr || op_ror || op_rrc;
            sft_l <= op_asr || op_lsr || op_rol || op_rlc;

            // rjp leaves the flags alone
            set_psw <= (op == OP_CLR) || is_shift || (op == OP_MOV) ||
                       (arith && (op != OP_RJP)) || logic_op;
        end
    end

endmodule

/* hw/bus_control.sv */
`timescale 1ns/1ps

module bus_control (
    input  logic clk,
    input  logic rst,
    input  logic if_0,
    input  logic if_1,
    input  logic ff_0,
    input  logic ff_2,
    input  logic tf_0,
    input  logic tf_1,
    input  logic ex_1,
    input  logic op_mem_idle,
    input  logic op_dst_write,
    input  logic op_call,
    output logic smd,
    output logic sma,
    output logic sb0,
    output logic r_w_n,
    output logic mreq_n,
    output logic mirq_n,
    output logic mis,
    output logic mmd,
    output logic mdm
);

    logic addr_cycle;
    logic quiet;

    // cycles that put an address out on the memory bus
    assign addr_cycle = if_0 || ff_0 || tf_0;

    // memory held idle, no write and no request
    assign quiet = addr_cycle || if_1 || ff_2 || op_mem_idle;

    always_ff @(posedge clk) begin
        if (rst) begin
            {smd, sma, sb0, r_w_n, mreq_n, mirq_n, mis, mmd, mdm} <= '0;
        end else begin
            smd    <= addr_cycle || op_dst_write || op_call;
            sma    <= addr_cycle;
            sb0    <= ff_2;
            r_w_n  <= quiet || tf_1;
            mreq_n <= quiet || ex_1;
            mirq_n <= quiet || tf_1;
            mis    <= if_1;
            mmd    <= if_1 || tf_1;
            mdm    <= ex_1;
        end
    end

endmodule

/* hw/cpu_ctrl_decoder.sv */
`timescale 1ns/1ps

module cpu_ctrl_decoder (
    input  logic                              clk,
    input  logic                              rst,
    input  cpu_ctrl_pkg::isr_u                isr,
    input  logic                              if_0,
    input  logic                              if_1,
    input  logic                              ff_0,
    input  logic                              ff_1,
    input  logic                              ff_2,
    input  logic                              tf_0,
    input  logic                              tf_1,
    input  logic                              ex_1,
    input  logic                              psw_n,
    input  logic                              psw_z,
    input  logic                              psw_v,
    input  logic                              psw_c,
    output logic [cpu_ctrl_pkg::NUM_REGS-1:0] reg_read,
    output logic [cpu_ctrl_pkg::NUM_REGS-1:0] reg_write,
    output logic                              mda,
    output logic                              b0b,
    output logic                              als,
    output logic                              alu_x,
    output logic                              alu_y,
    output logic                              alu_z,
    output logic                              alu_u,
    output logic                              alu_v,
    output logic                              shs,
    output logic                              sft_a,
    output logic                              sft_b,
    output logic                              sft_c,
    output logic                              sft_d,
    output logic                              sft_e,
    output logic                              sft_r,
    output logic                              sft_l,
    output logic                              set_psw,
    output logic                              smd,
    output logic                              sma,
    output logic                              sb0,
    output logic                              r_w_n,
    output logic                              mreq_n,
    output logic                              mirq_n,
    output logic                              mis,
    output logic                              mmd,
    output logic                              mdm
);

    // class flags shared by the registered stages
    logic op_dst_write;
    logic op_jump;
    logic op_stack_ret;
    logic op_call;
    logic op_rjs;
    logic op_branch_taken;
    logic op_rel_branch;
    logic op_mem_idle;
    logic f_is_ip;
    logic f_is_mi;
    logic t_is_ip;
    logic t_is_d;

    // port names match the local nets one to one
    opcode_decoder i_opcode_decoder (.*);

    reg_select i_reg_select (.*);

    alu_control i_alu_control (.*);

    bus_control i_bus_control (.*);

endmodule

/* tb/cpu_ctrl_decoder_props.sv */
`timescale 1ns/1ps

module cpu_ctrl_decoder_props (
    input logic                              clk,
    input logic                              rst,
    input logic [4:0]                        operand_phase,
    input logic [cpu_ctrl_pkg::NUM_REGS-1:0] reg_read,
    input logic [cpu_ctrl_pkg::NUM_REGS-1:0] reg_write,
    input logic [16:0]                       alu_bits,
    input logic [8:0]                        bus_bits,
    input logic                              shs,
    input logic                              set_psw
);

    // a single operand phase reads at most one register
    assert property (@(posedge clk) disable iff (rst)
        $onehot(operand_phase) |=> $onehot0(reg_read))
        else $error("reg_read has more than one bit set after a single operand phase");

    assert property (@(posedge clk)
        rst |=> (reg_read == '0 && reg_write == '0 && alu_bits == '0 && bus_bits == '0))
        else $error("outputs not cleared in the cycle after reset");

    assert property (@(posedge clk) disable iff (rst) shs |-> set_psw)
        else $error("shs without set_psw");

endmodule

bind cpu_ctrl_decoder cpu_ctrl_decoder_props i_props (
    .clk           (clk),
    .rst           (rst),
    .operand_phase ({ff_0, ff_1, ff_2, tf_0, tf_1}),
    .reg_read      (reg_read),
    .reg_write     (reg_write),
    .alu_bits      ({mda, b0b, als, alu_x, alu_y, alu_z, alu_u, alu_v, shs, sft_a, sft_b,
                     sft_c, sft_d, sft_e, sft_r, sft_l, set_psw}),
    .bus_bits      ({smd, sma, sb0, r_w_n, mreq_n, mirq_n, mis, mmd, mdm}),
    .shs           (shs),
    .set_psw       (set_psw)
);

/* tb/cpu_ctrl_decoder_tb.sv */
`timescale 1ns/1ps

module cpu_ctrl_decoder_tb;
    import cpu_ctrl_pkg::*;

    // phase vector order {if_0, if_1, ff_0, ff_1, ff_2, tf_0, tf_1, ex_1}
    localparam logic [7:0] S_IF0 = 8'h80;
    localparam logic [7:0] S_IF1 = 8'h40;
    localparam logic [7:0] S_FF0 = 8'h20;
    localparam logic [7:0] S_FF1 = 8'h10;
    localparam logic [7:0] S_TF1 = 8'h02;
    localparam logic [7:0] S_EX1 = 8'h01;

    // ctrl vector {shs, sft_a..sft_l, alu_u, set_psw}
    // psw vector {n, z, v, c}
    typedef struct packed {
        isr_u                isr;
        logic [7:0]          phase;
        logic [3:0]          psw;
        logic [NUM_REGS-1:0] exp_read;
        logic [NUM_REGS-1:0] exp_write;
        logic [9:0]          exp_ctrl;
    } entry_t;

    logic                clk;
    logic                rst;
    isr_u                isr;
    logic                if_0;
    logic                if_1;
    logic                ff_0;
    logic                ff_1;
    logic                ff_2;
    logic                tf_0;
    logic                tf_1;
    logic                ex_1;
    logic                psw_n;
    logic                psw_z;
    logic                psw_v;
    logic                psw_c;
    logic [NUM_REGS-1:0] reg_read;
    logic [NUM_REGS-1:0] reg_write;
    logic                mda;
    logic                b0b;
    logic                als;
    logic                alu_x;
    logic                alu_y;
    logic                alu_z;
    logic                alu_u;
    logic                alu_v;
    logic                shs;
    logic                sft_a;
    logic                sft_b;
    logic                sft_c;
    logic                sft_d;
    logic                sft_e;
    logic                sft_r;
    logic                sft_l;
    logic                set_psw;
    logic                smd;
    logic                sma;
    logic                sb0;
    logic                r_w_n;
    logic                mreq_n;
    logic                mirq_n;
    logic                mis;
    logic                mmd;
    logic                mdm;

    entry_t tbl[$];
    entry_t idle_entry = '0;
    int     cycles = 0;
    int     max_cycles = 0;

    cpu_ctrl_decoder i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (max_cycles > 0 && cycles > max_cycles) begin
            $display("timeout: the run went past %0d cycles without finishing", max_cycles);
            stop_run();
        end
    end

    function automatic logic [REG_W-1:0] random_reg();
        logic [31:0] r;
        r = $urandom;
        return r[REG_W-1:0];
    endfunction

    function automatic logic [NUM_REGS-1:0] onehot(input logic [REG_W-1:0] r);
        return NUM_REGS'(1) << r;
    endfunction

    function automatic isr_u make_isr(input logic [OP_W-1:0] op,
                                      input logic [MODE_W-1:0] fm, input logic [REG_W-1:0] fr,
                                      input logic [MODE_W-1:0] tm, input logic [REG_W-1:0] tr);
        isr_u w;
        w.fields.ex_op  = op;
        w.fields.f_mode = fm;
        w.fields.f_reg  = fr;
        w.fields.t_mode = tm;
        w.fields.t_reg  = tr;
        return w;
    endfunction

    task automatic add_entry(input isr_u w, input logic [7:0] phase, input logic [3:0] psw,
                             input logic [NUM_REGS-1:0] rd, input logic [NUM_REGS-1:0] wr,
                             input logic [9:0] ctrl);
        entry_t e;
        e.isr       = w;
        e.phase     = phase;
        e.psw       = psw;
        e.exp_read  = rd;
        e.exp_write = wr;
        e.exp_ctrl  = ctrl;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        logic [REG_W-1:0] fr;
        logic [REG_W-1:0] tr;
        logic [31:0]      pick;
        // operand fetch
        fr = random_reg();
        tr = random_reg();
        add_entry(make_isr(OP_HLT, MODE_D, fr, MODE_I, tr), S_FF0, 4'h0, onehot(fr), onehot(fr),
                  10'h000);
        add_entry(make_isr(OP_HLT, MODE_IP, fr, MODE_I, tr), S_FF1, 4'h0, onehot(fr),
                  onehot(fr), 10'h000);
        add_entry(make_isr(OP_HLT, MODE_I, fr, MODE_IP, tr), S_TF1, 4'h0, onehot(tr),
                  onehot(tr), 10'h002);
        // direct-mode write-back
        tr = random_reg();
        add_entry(make_isr(OP_ADD, MODE_D, fr, MODE_D, tr), S_EX1, 4'h0, '0, onehot(tr), 10'h001);
        add_entry(make_isr(OP_MOV, MODE_D, fr, MODE_D, tr), S_EX1, 4'h0, '0, onehot(tr), 10'h001);
        add_entry(make_isr(OP_ASL, MODE_D, fr, MODE_D, tr), S_EX1, 4'h0, '0, onehot(tr), 10'h201);
        add_entry(make_isr(OP_CMP, MODE_D, fr, MODE_D, tr), S_EX1, 4'h0, '0, '0, 10'h003);
        // op_sub picks the branch flag from n, z, v and c
        add_entry(make_isr({GRP_BR, 2'd0}, MODE_I, fr, MODE_I, tr), S_EX1, 4'h8, '0, 8'h80, '0);
        add_entry(make_isr({GRP_BR, 2'd0}, MODE_I, fr, MODE_I, tr), S_EX1, 4'h4, '0, '0, '0);
        add_entry(make_isr({GRP_RB, 2'd3}, MODE_I, fr, MODE_I, tr), S_EX1, 4'h1, '0, 8'h80, '0);
        add_entry(make_isr({GRP_RB, 2'd2}, MODE_I, fr, MODE_I, tr), S_EX1, 4'hd, '0, '0, '0);
        add_entry(make_isr(OP_RET, MODE_I, fr, MODE_I, tr), S_EX1, 4'h0, 8'h40, 8'h80, '0);
        add_entry(make_isr(OP_RIT, MODE_I, fr, MODE_I, tr), S_EX1, 4'h0, 8'h40, 8'h80, '0);
        // shifter patterns {a, b, c, d, e, r, l}
        add_entry(make_isr(OP_ASL, MODE_I, fr, MODE_I, tr), S_EX1, 4'h0, '0, '0,
                  {1'b1, 7'b0000000, 2'b01});
        add_entry(make_isr(OP_ASR, MODE_I, fr, MODE_I, tr), S_EX1, 4'h0, '0, '0,
                  {1'b1, 7'b1000011, 2'b01});
        add_entry(make_isr(OP_RLC, MODE_I, fr, MODE_I, tr), S_EX1, 4'h0, '0, '0,
                  {1'b1, 7'b0010101, 2'b01});
        add_entry(make_isr(OP_RRC, MODE_I, fr, MODE_I, tr), S_EX1, 4'h0, '0, '0,
                  {1'b1, 7'b0000110, 2'b01});
        add_entry(make_isr(OP_LSL, MODE_I, fr, MODE_I, tr), S_EX1, 4'h0, '0, '0,
                  {1'b1, 7'b0000000, 2'b01});
        add_entry(make_isr(OP_LSR, MODE_I, fr, MODE_I, tr), S_EX1, 4'h0, '0, '0,
                  {1'b1, 7'b0010001, 2'b01});
        add_entry(make_isr(OP_ROL, MODE_I, fr, MODE_I, tr), S_EX1, 4'h0, '0, '0,
                  {1'b1, 7'b0110001, 2'b01});
        add_entry(make_isr(OP_ROR, MODE_I, fr, MODE_I, tr), S_EX1, 4'h0, '0, '0,
                  {1'b1, 7'b0001010, 2'b01});
        // carry in follows psw_c for adc and sbc only
        add_entry(make_isr(OP_ADC, MODE_I, fr, MODE_I, tr), S_EX1, 4'h1, '0, '0, 10'h003);
        add_entry(make_isr(OP_ADC, MODE_I, fr, MODE_I, tr), S_EX1, 4'he, '0, '0, 10'h001);
        add_entry(make_isr(OP_SBC, MODE_I, fr, MODE_I, tr), S_EX1, 4'h1, '0, '0, 10'h003);
        add_entry(make_isr(OP_SBC, MODE_I, fr, MODE_I, tr), S_EX1, 4'h0, '0, '0, 10'h001);
        // fetch
        add_entry(make_isr(OP_HLT, MODE_I, fr, MODE_I, tr), S_IF1, 4'h0, 8'h80, 8'h80, 10'h002);
        add_entry(make_isr(OP_HLT, MODE_I, fr, MODE_I, tr), S_IF0, 4'h0, 8'h80, '0, 10'h000);
        // back-to-back random stream
        for (int i = 0; i < 16; i++) begin
            fr   = random_reg();
            tr   = random_reg();
            pick = $urandom;
            case (pick % 3)
                0: add_entry(make_isr(OP_HLT, MODE_D, fr, MODE_I, tr), S_FF0, 4'h0,
                             onehot(fr), onehot(fr), 10'h000);
                1: add_entry(make_isr(OP_HLT, MODE_D, fr, MODE_IP, tr), S_TF1, 4'h0,
                             onehot(tr), onehot(tr), 10'h002);
                default: add_entry(make_isr(OP_HLT, MODE_D, fr, MODE_I, tr), S_IF1, 4'h0,
                                   8'h80, 8'h80, 10'h002);
            endcase
        end
    endtask

    task automatic check_sel(input string name, input logic [NUM_REGS-1:0] got,
                             input logic [NUM_REGS-1:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_ctrl(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_entry(input entry_t e);
        check_sel("reg_read", reg_read, e.exp_read);
        check_sel("reg_write", reg_write, e.exp_write);
        check_ctrl("shs", shs, e.exp_ctrl[9]);
        check_ctrl("sft_a", sft_a, e.exp_ctrl[8]);
        check_ctrl("sft_b", sft_b, e.exp_ctrl[7]);
        check_ctrl("sft_c", sft_c, e.exp_ctrl[6]);
        check_ctrl("sft_d", sft_d, e.exp_ctrl[5]);
        check_ctrl("sft_e", sft_e, e.exp_ctrl[4]);
        check_ctrl("sft_r", sft_r, e.exp_ctrl[3]);
        check_ctrl("sft_l", sft_l, e.exp_ctrl[2]);
        check_ctrl("alu_u", alu_u, e.exp_ctrl[1]);
        check_ctrl("set_psw", set_psw, e.exp_ctrl[0]);
        // mis follows if_1 and mmd follows if_1 or tf_1
        check_strobe("mis", mis, e.phase[6]);
        check_strobe("mmd", mmd, e.phase[6] | e.phase[1]);
    endtask

    // every output register cleared by rst
    task automatic check_reset_state();
        check_sel("reg_read", reg_read, '0);
        check_sel("reg_write", reg_write, '0);
        check_ctrl("mda", mda, 1'b0);
        check_ctrl("b0b", b0b, 1'b0);
        check_ctrl("als", als, 1'b0);
        check_ctrl("alu_x", alu_x, 1'b0);
        check_ctrl("alu_y", alu_y, 1'b0);
        check_ctrl("alu_z", alu_z, 1'b0);
        check_ctrl("alu_u", alu_u, 1'b0);
        check_ctrl("alu_v", alu_v, 1'b0);
        check_ctrl("shs", shs, 1'b0);
        check_ctrl("sft_a", sft_a, 1'b0);
        check_ctrl("sft_b", sft_b, 1'b0);
        check_ctrl("sft_c", sft_c, 1'b0);
        check_ctrl("sft_d", sft_d, 1'b0);
        check_ctrl("sft_e", sft_e, 1'b0);
        check_ctrl("sft_r", sft_r, 1'b0);
        check_ctrl("sft_l", sft_l, 1'b0);
        check_ctrl("set_psw", set_psw, 1'b0);
        check_strobe("smd", smd, 1'b0);
        check_strobe("sma", sma, 1'b0);
        check_strobe("sb0", sb0, 1'b0);
        check_strobe("r_w_n", r_w_n, 1'b0);
        check_strobe("mreq_n", mreq_n, 1'b0);
        check_strobe("mirq_n", mirq_n, 1'b0);
        check_strobe("mis", mis, 1'b0);
        check_strobe("mmd", mmd, 1'b0);
        check_strobe("mdm", mdm, 1'b0);
    endtask

    task apply_entry(input entry_t e);
        isr <= e.isr;
        {if_0, if_1, ff_0, ff_1, ff_2, tf_0, tf_1, ex_1} <= e.phase;
        {psw_n, psw_z, psw_v, psw_c} <= e.psw;
    endtask

    initial begin
        void'($urandom(32'h15d2_cb45));
        rst   = 1'b1;
        isr   = '0;
        if_0  = 1'b0;
        if_1  = 1'b0;
        ff_0  = 1'b0;
        ff_1  = 1'b0;
        ff_2  = 1'b0;
        tf_0  = 1'b0;
        tf_1  = 1'b0;
        ex_1  = 1'b0;
        psw_n = 1'b0;
        psw_z = 1'b0;
        psw_v = 1'b0;
        psw_c = 1'b0;
        build_table();
        max_cycles = tbl.size() + 20;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_reset_state();
        // entry k-1 is checked while entry k is in flight
        for (int k = 0; k <= tbl.size(); k++) begin
            @(posedge clk);
            if (k < tbl.size()) begin
                apply_entry(tbl[k]);
            end else begin
                apply_entry(idle_entry);
            end
            @(negedge clk);
            if (k > 0) begin
                check_entry(tbl[k-1]);
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

/* cpu_ctrl_decoder.f */
hw/cpu_ctrl_pkg.sv
hw/opcode_decoder.sv
hw/reg_select.sv
hw/alu_control.sv
hw/bus_control.sv
hw/cpu_ctrl_decoder.sv
tb/cpu_ctrl_decoder_props.sv
tb/cpu_ctrl_decoder_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cpu_ctrl_decoder_tb
FILELIST  ?= cpu_ctrl_decoder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG) || ! grep -q "All checks passed" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
